//--- Bender.yml
package:
  name: lcd_ctrl

sources:
  - common/lcd_pkg.sv
  - hw/axil_lcd_regs.sv
  - lcd/lcd_sequencer.sv
  - lcd/lcd_timer.sv
  - lcd/lcd_cmd_encoder.sv
  - hw/lcd_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/lcd_tb.sv

//--- common/lcd_pkg.sv
package lcd_pkg;

	localparam int lcd_data_w  = 8;
	localparam int us_w        = 10;  // up to 1023 us
	localparam int axil_addr_w = 4;
	localparam int axil_data_w = 32;

	typedef logic [lcd_data_w-1:0]  lcd_byte_t;
	typedef logic [us_w-1:0]        us_count_t;
	typedef logic [axil_addr_w-1:0] axil_addr_t;
	typedef logic [axil_data_w-1:0] axil_data_t;

	// register map, byte addresses
	localparam axil_addr_t reg_cfg    = 4'h0;
	localparam axil_addr_t reg_ctrl   = 4'h4;
	localparam axil_addr_t reg_cmd    = 4'h8;
	localparam axil_addr_t reg_status = 4'hC;

	// host transfer, rs in bit 9
	typedef struct packed {
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_xfer_t;

	// option bits, lines in bit 6
	typedef struct packed {
		logic lines;
		logic font;
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;
		logic shift;
	} lcd_cfg_t;

	typedef struct packed {
		logic      e;
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_pins_t;

	// what the encoder puts on the bus
	typedef enum logic [2:0] {
		step_idle,
		step_wake,
		step_func_set,
		step_disp_ctrl,
		step_clear,
		step_entry_mode,
		step_host
	} lcd_step_e;

	typedef enum logic [1:0] {
		st_power_wait,
		st_init_run,
		st_ready,
		st_xfer
	} seq_state_e;

endpackage

//--- hw/axil_lcd_regs.sv
`timescale 1ns/1ps

module axil_lcd_regs (
	input  logic                clk,
	input  logic                arst_n,
	input  lcd_pkg::axil_addr_t awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  lcd_pkg::axil_data_t wdata,
	input  logic                wvalid,
	output logic                wready,
	output logic                bvalid,
	output logic [1:0]          bresp,
	input  logic                bready,
	input  lcd_pkg::axil_addr_t araddr,
	input  logic                arvalid,
	output logic                arready,
	output lcd_pkg::axil_data_t rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	output lcd_pkg::lcd_cfg_t   cfg,
	output logic                start,
	output lcd_pkg::lcd_xfer_t  xfer,
	output logic                xfer_valid,
	input  logic                xfer_ready,
	input  logic                init_done,
	input  logic                busy
);
	import lcd_pkg::*;

	logic       aw_hs;
	logic       wr_pend;     // write accepted, not yet applied
	axil_addr_t wr_addr;
	axil_data_t wr_data;
	axil_addr_t addr_w;
	axil_data_t data_w;
	logic       wr_blocked;
	axil_data_t rd_word;

	assign aw_hs = awvalid && awready && wvalid && wready;
	assign addr_w = aw_hs ? awaddr : wr_addr;
	assign data_w = aw_hs ? wdata : wr_data;
	// holding register still full and not drained this cycle
	assign wr_blocked = (addr_w == reg_cmd) && xfer_valid && !xfer_ready;

	assign wready = awready;  // address and data are taken together
	assign bresp  = 2'b00;
	assign rresp  = 2'b00;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready    <= 1'b0;
			wr_pend    <= 1'b0;
			bvalid     <= 1'b0;
			cfg        <= '0;
			start      <= 1'b0;
			xfer_valid <= 1'b0;
		end else begin
			awready <= 1'b0;
			start   <= 1'b0;
			if (awvalid && wvalid && !awready && !wr_pend && !bvalid)
				awready <= 1'b1;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (xfer_valid && xfer_ready)
				xfer_valid <= 1'b0;  // sequencer took it
			if (aw_hs || wr_pend) begin
				if (wr_blocked) begin
					wr_pend <= 1'b1;  // response waits for a free slot
				end else begin
					wr_pend <= 1'b0;
					bvalid  <= 1'b1;
					case (addr_w)
						reg_cfg:  cfg <= lcd_cfg_t'(data_w[6:0]);
						reg_ctrl: start <= data_w[0];
						reg_cmd:  xfer_valid <= 1'b1;  // overrides the drain above
						default: ;
					endcase
				end
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wr_addr <= awaddr;
			wr_data <= wdata;
		end
		if ((aw_hs || wr_pend) && !wr_blocked && addr_w == reg_cmd)
			xfer <= lcd_xfer_t'(data_w[9:0]);
	end

	always_comb begin
		rd_word = '0;
		case (araddr)
			reg_cfg:    rd_word = {25'd0, cfg};
			reg_cmd:    rd_word = {15'd0, xfer_valid, 6'd0, xfer};  // pending flag in bit 16
			reg_status: rd_word = {30'd0, busy, init_done};
			default: ;  // ctrl is write only
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rdata <= rd_word;
	end

endmodule

//--- hw/lcd_top.sv
`timescale 1ns/1ps

module lcd_top #(
	parameter int clk_per_us = 25
) (
	input  logic                clk,
	input  logic                arst_n,
	input  lcd_pkg::axil_addr_t awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  lcd_pkg::axil_data_t wdata,
	input  logic                wvalid,
	output logic                wready,
	output logic                bvalid,
	output logic [1:0]          bresp,
	input  logic                bready,
	input  lcd_pkg::axil_addr_t araddr,
	input  logic                arvalid,
	output logic                arready,
	output lcd_pkg::axil_data_t rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	output logic                lcd_e,
	output logic                lcd_rs,
	output logic                lcd_rw,
	output lcd_pkg::lcd_byte_t  lcd_data
);
	import lcd_pkg::*;

	lcd_cfg_t  cfg;
	lcd_xfer_t xfer;
	lcd_step_e step;
	lcd_pins_t pins;
	us_count_t tmr_us;
	logic      start;
	logic      xfer_valid;
	logic      xfer_ready;
	logic      init_done;
	logic      busy;
	logic      e_on;
	logic      tmr_load;
	logic      tmr_done;
	logic      capture;

	assign capture = xfer_valid & xfer_ready;  // handshake into the encoder

	axil_lcd_regs regs0 (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bvalid, .bresp, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.cfg, .start, .xfer, .xfer_valid, .xfer_ready, .init_done, .busy
	);

	lcd_sequencer seq0 (
		.clk, .arst_n, .start, .xfer_valid, .xfer_ready, .step, .e_on,
		.tmr_load, .tmr_us, .tmr_done, .init_done, .busy
	);

	lcd_timer #(.clk_per_us(clk_per_us)) tmr0 (
		.clk, .arst_n, .load(tmr_load), .us(tmr_us), .done(tmr_done)
	);

	lcd_cmd_encoder enc0 (
		.clk, .arst_n, .step, .e_on, .cfg, .xfer, .capture, .pins
	);

	assign lcd_e    = pins.e;
	assign lcd_rs   = pins.rs;
	assign lcd_rw   = pins.rw;
	assign lcd_data = pins.data;

endmodule

//--- lcd/lcd_cmd_encoder.sv
`timescale 1ns/1ps

module lcd_cmd_encoder (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::lcd_step_e step,
	input  logic               e_on,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  lcd_pkg::lcd_xfer_t xfer,
	input  logic               capture,
	output lcd_pkg::lcd_pins_t pins
);
	import lcd_pkg::*;

	lcd_xfer_t xfer_q;  // transfer being sent
	lcd_byte_t data_d;
	logic      rs_d;
	logic      rw_d;

	always_ff @(posedge clk) begin
		if (capture)
			xfer_q <= xfer;
	end

	always_comb begin
		data_d = '0;
		rs_d   = 1'b0;
		rw_d   = 1'b0;
		case (step)
			step_wake:       data_d = 8'h30;
			step_func_set:   data_d = {4'b0011, cfg.lines, cfg.font, 2'b00};
			step_disp_ctrl:  data_d = {5'b00001, cfg.display_on, cfg.cursor, cfg.blink};
			step_clear:      data_d = 8'h01;
			step_entry_mode: data_d = {6'b000001, cfg.inc_dec, cfg.shift};
			step_host: begin
				data_d = xfer_q.data;
				rs_d   = xfer_q.rs;
				rw_d   = xfer_q.rw;  // driven as asked, bus stays output
			end
			default: ;  // idle bus is all zero
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pins <= '0;
		end else begin
			pins.e    <= e_on;
			pins.rs   <= rs_d;
			pins.rw   <= rw_d;
			pins.data <= data_d;
		end
	end

endmodule

//--- lcd/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  logic               xfer_valid,
	output logic               xfer_ready,
	output lcd_pkg::lcd_step_e step,
	output logic               e_on,
	output logic               tmr_load,
	output lcd_pkg::us_count_t tmr_us,
	input  logic               tmr_done,
	output logic               init_done,
	output logic               busy
);
	import lcd_pkg::*;

	// wake pulse and its gap come out of the 500 us power-up wait
	localparam us_count_t power_us = 10'd480;
	localparam us_count_t pulse_us = 10'd10;
	localparam us_count_t setup_us = 10'd1;
	localparam us_count_t high_us  = 10'd13;
	localparam us_count_t tail_us  = 10'd36;  // rest of the 50 us slot
	localparam logic [3:0] last_phase = 4'd9;

	seq_state_e state, state_d;
	logic [3:0] phase, phase_d;  // init: {command index, wait bit}
	logic       busy_d;
	logic       init_done_d;

	function automatic lcd_step_e init_step(input logic [2:0] idx);
		case (idx)
			3'd0:    return step_wake;
			3'd1:    return step_func_set;
			3'd2:    return step_disp_ctrl;
			3'd3:    return step_clear;
			default: return step_entry_mode;
		endcase
	endfunction

	function automatic us_count_t init_wait_us(input logic [2:0] idx);
		case (idx)
			3'd0:    return 10'd10;
			3'd1:    return 10'd50;
			3'd2:    return 10'd50;
			3'd3:    return 10'd200;  // clear is slow
			default: return 10'd100;
		endcase
	endfunction

	assign xfer_ready = (state == st_ready) && !start;

	always_comb begin
		step = step_idle;
		e_on = 1'b0;
		case (state)
			st_init_run: begin
				step = init_step(phase[3:1]);
				e_on = !phase[0];
			end
			st_xfer: begin
				step = step_host;
				e_on = (phase == 4'd1);
			end
			default: ;
		endcase
	end

	always_comb begin
		state_d     = state;
		phase_d     = phase;
		busy_d      = busy;
		init_done_d = init_done;
		tmr_load    = 1'b0;
		tmr_us      = '0;
		case (state)
			st_power_wait: begin
				if (!busy) begin
					if (start) begin
						busy_d   = 1'b1;
						tmr_load = 1'b1;
						tmr_us   = power_us;
					end
				end else if (tmr_done) begin
					state_d  = st_init_run;
					phase_d  = '0;
					tmr_load = 1'b1;
					tmr_us   = pulse_us;
				end
			end
			st_init_run: begin
				if (tmr_done) begin
					if (phase == last_phase) begin
						state_d     = st_ready;
						busy_d      = 1'b0;
						init_done_d = 1'b1;
					end else begin
						phase_d  = phase + 4'd1;
						tmr_load = 1'b1;
						tmr_us   = phase[0] ? pulse_us : init_wait_us(phase[3:1]);
					end
				end
			end
			st_ready: begin
				if (start) begin  // re-run init
					state_d     = st_power_wait;
					busy_d      = 1'b1;
					init_done_d = 1'b0;
					tmr_load    = 1'b1;
					tmr_us      = power_us;
				end else if (xfer_valid) begin
					state_d  = st_xfer;
					phase_d  = '0;
					busy_d   = 1'b1;
					tmr_load = 1'b1;
					tmr_us   = setup_us;
				end
			end
			default: begin
				if (tmr_done) begin
					phase_d  = phase + 4'd1;
					tmr_load = 1'b1;
					case (phase)
						4'd0: tmr_us = high_us;
						4'd1: tmr_us = tail_us;
						default: begin
							state_d  = st_ready;
							busy_d   = 1'b0;
							tmr_load = 1'b0;
						end
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_power_wait;
			phase     <= '0;
			busy      <= 1'b0;
			init_done <= 1'b0;
		end else begin
			state     <= state_d;
			phase     <= phase_d;
			busy      <= busy_d;
			init_done <= init_done_d;
		end
	end

endmodule

//--- lcd/lcd_timer.sv
`timescale 1ns/1ps

module lcd_timer #(
	parameter int clk_per_us = 25
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               load,
	input  lcd_pkg::us_count_t us,
	output logic               done
);
	import lcd_pkg::*;

	localparam int pre_w = $clog2(clk_per_us + 1);
	localparam logic [pre_w-1:0] pre_top = pre_w'(clk_per_us - 1);

	logic [pre_w-1:0] pre;      // cycles left in this microsecond
	us_count_t        us_left;
	logic             active;

	// high in the last cycle of the interval
	assign done = active && (pre == '0) && (us_left == us_count_t'(1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre     <= '0;
			us_left <= '0;
			active  <= 1'b0;
		end else if (load) begin
			pre     <= pre_top;
			us_left <= us;
			active  <= (us != '0);
		end else if (active) begin
			if (pre == '0) begin
				pre     <= pre_top;
				us_left <= us_left - us_count_t'(1);
				if (us_left == us_count_t'(1))
					active <= 1'b0;
			end else begin
				pre <= pre - 1'b1;
			end
		end
	end

endmodule

//--- tb.f
common/lcd_pkg.sv
hw/axil_lcd_regs.sv
lcd/lcd_sequencer.sv
lcd/lcd_timer.sv
lcd/lcd_cmd_encoder.sv
hw/lcd_top.sv
tb/tb_clkgen.sv
tb/lcd_tb.sv

//--- tb/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;
	import lcd_pkg::*;

	localparam int clk_per_us = 25;
	localparam int n_host     = 12;  // back-to-back host writes
	localparam int n_early    = 2;   // writes issued before init is done
	localparam int init_us    = 940;
	localparam int init_high  = 10 * clk_per_us;
	localparam int host_high  = 13 * clk_per_us;
	localparam int tol        = 2;   // cycles
	localparam int limit_us   = 2 * init_us + (n_host + n_early) * 60 + 500;

	logic       clk;
	logic       arst_n;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	axil_data_t wdata;
	logic       wvalid;
	logic       wready;
	logic       bvalid;
	logic [1:0] bresp;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	axil_data_t rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;
	logic       lcd_e;
	logic       lcd_rs;
	logic       lcd_rw;
	lcd_byte_t  lcd_data;

	lcd_xfer_t  exp_q[$];       // model of the pulses still to come
	int         exp_high_q[$];
	int         seen;
	int         high_cnt;
	int         mon_high;
	logic       e_q = 1'b0;
	lcd_xfer_t  pins_q;         // bus while e is high
	lcd_xfer_t  mon_exp;

	tb_clkgen #(.period_ns(40), .reset_cycles(5)) clkgen0 (.clk, .arst_n);

	lcd_top #(.clk_per_us(clk_per_us)) dut0 (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bvalid, .bresp, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.lcd_e, .lcd_rs, .lcd_rw, .lcd_data
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// gives back exp when act is close enough
	function automatic int tol_match(input int exp, input int act);
		return ((act >= exp - tol) && (act <= exp + tol)) ? exp : act;
	endfunction

	task automatic push_pulse(input lcd_xfer_t x, input int high);
		exp_q.push_back(x);
		exp_high_q.push_back(high);
	endtask

	// HD44780 init bytes with rs and rw low
	task automatic expect_init(input lcd_cfg_t c);
		push_pulse({2'b00, 8'h30}, init_high);
		push_pulse({2'b00, 4'b0011, c.lines, c.font, 2'b00}, init_high);
		push_pulse({2'b00, 5'b00001, c.display_on, c.cursor, c.blink}, init_high);
		push_pulse({2'b00, 8'h01}, init_high);
		push_pulse({2'b00, 6'b000001, c.inc_dec, c.shift}, init_high);
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data, input int bdelay);
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wvalid  <= 1'b1;
		do @(posedge clk); while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat (bdelay) @(posedge clk);
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		bready <= 1'b0;
		check("write response", 32'd0, bresp);
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk); while (!rvalid);
		rready <= 1'b0;
		data = rdata;
		check("read response", 32'd0, rresp);
	endtask

	// polls status until init_done is set and busy is clear
	task automatic wait_idle();
		axil_data_t st;
		st = '0;
		while (st != 32'h1) begin
			repeat (10 * clk_per_us) @(posedge clk);
			axi_read(reg_status, st);
		end
	endtask

	// pulse monitor sees e as it was before the edge
	always @(posedge clk) begin
		e_q <= lcd_e;
		if (lcd_e) begin
			high_cnt <= e_q ? high_cnt + 1 : 1;
			pins_q   <= {lcd_rs, lcd_rw, lcd_data};
		end else if (e_q) begin
			if (exp_q.size() == 0) begin
				fail_run("an e pulse appeared with no transfer expected");
			end else begin
				mon_exp  = exp_q.pop_front();
				mon_high = exp_high_q.pop_front();
				check($sformatf("pulse %0d bus", seen), mon_exp, pins_q);
				check($sformatf("pulse %0d e high cycles", seen), mon_high,
					tol_match(mon_high, high_cnt));
				seen++;
			end
		end
	end

	initial begin
		#(limit_us * 1000);
		fail_run($sformatf("timeout: run not finished after %0d us", limit_us));
	end

	initial begin
		lcd_cfg_t   cfg;
		lcd_xfer_t  x;
		axil_data_t rd;
		void'($urandom(68004));
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		seen    = 0;
		wait (arst_n === 1'b1);
		@(posedge clk);

		check("reset pins", 32'd0, {lcd_e, lcd_rs, lcd_rw, lcd_data});
		axi_read(reg_status, rd);
		check("reset status", 32'd0, rd);

		cfg = lcd_cfg_t'(7'($urandom));
		axi_write(reg_cfg, {25'd0, cfg}, $urandom_range(0, 3));
		axi_read(reg_cfg, rd);
		check("cfg readback", {25'd0, cfg}, rd);
		axi_read({2'($urandom), 2'($urandom_range(1, 3))}, rd);  // off the word grid
		check("unmapped read", 32'd0, rd);

		expect_init(cfg);
		axi_write(reg_ctrl, 32'd1, 0);
		wait_idle();
		check("init pulse count", 32'd5, seen);

		for (int i = 0; i < n_host; i++) begin
			x = lcd_xfer_t'(10'($urandom));
			push_pulse(x, host_high);
			axi_write(reg_cmd, {22'd0, x}, $urandom_range(0, 8));
		end
		while (exp_q.size() != 0) @(posedge clk);
		wait_idle();

		// second init with commands queued behind it
		cfg = lcd_cfg_t'(7'($urandom));
		axi_write(reg_cfg, {25'd0, cfg}, $urandom_range(0, 3));
		axi_read(reg_cfg, rd);
		check("cfg readback after rewrite", {25'd0, cfg}, rd);
		expect_init(cfg);
		axi_write(reg_ctrl, 32'd1, 0);
		for (int i = 0; i < n_early; i++) begin
			x = lcd_xfer_t'(10'($urandom));
			push_pulse(x, host_high);
			axi_write(reg_cmd, {22'd0, x}, $urandom_range(0, 8));
		end

		while (exp_q.size() != 0) @(posedge clk);
		wait_idle();
		repeat (60 * clk_per_us) @(posedge clk);  // room for a stray pulse
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 5
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;  // released on a rising edge
	end

endmodule
